/* verilog/video_cfg.svh */
// video frame buffer configuration
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

//////////////////////////////////////////////////////////////////////
// raster timing
//////////////////////////////////////////////////////////////////////

// horizontal, in columns
`define H_ACTIVE   48
`define H_SYNC_ON  52
`define H_SYNC_OFF 58
`define H_TOTAL    64

// vertical, in lines
`define V_ACTIVE   24
`define V_SYNC_ON  26
`define V_SYNC_OFF 28
`define V_TOTAL    30

//////////////////////////////////////////////////////////////////////
// stored image and its window on screen
//////////////////////////////////////////////////////////////////////

// width must stay a power of two, address is {row, column}
`define IMG_W      16
`define IMG_H      8
`define X_OFF      8
`define Y_OFF      4

// bank read latency in cycles
`define RD_LAT     2
// grey shown around the image window
`define FILL_PIXEL 8'h80

`endif

/* verilog/video_pkg.sv */
// video frame buffer types
`include "video_cfg.svh"

package video_pkg;

   // who owns which bank, see bank_arbiter
   typedef enum logic [1:0] {
      mode_view,
      mode_source,
      mode_copy,
      mode_result
   } mode_t;

   // one byte of grey per pixel
   typedef logic [7:0] pixel_t;

   // bank address, row then column
   typedef logic [$clog2(`IMG_W * `IMG_H)-1:0] vaddr_t;

   // raster counters
   typedef logic [$clog2(`H_TOTAL)-1:0] hcount_t;
   typedef logic [$clog2(`V_TOTAL)-1:0] vcount_t;

endpackage

/* verilog/raster_timing.sv */
// raster sync and blank generator
`timescale 1ns/1ps
`include "video_cfg.svh"

module raster_timing
   import video_pkg::*;
(
   input  logic    clk,
   input  logic    arst_n,
   output hcount_t hcount,
   output vcount_t vcount,
   output logic    hsync,
   output logic    vsync,
   output logic    blank
);

   logic hblank;
   logic vblank;
   logic hblank_on;
   logic hsync_on;
   logic hsync_off;
   logic hreset;
   logic vblank_on;
   logic vsync_on;
   logic vsync_off;
   logic vreset;
   logic next_hblank;
   logic next_vblank;

   // decode one column early so every output is a register
   assign hblank_on = (hcount == hcount_t'(`H_ACTIVE - 1));
   assign hsync_on  = (hcount == hcount_t'(`H_SYNC_ON - 1));
   assign hsync_off = (hcount == hcount_t'(`H_SYNC_OFF - 1));
   assign hreset    = (hcount == hcount_t'(`H_TOTAL - 1));

   // line events only count on the last column
   assign vblank_on = hreset && (vcount == vcount_t'(`V_ACTIVE - 1));
   assign vsync_on  = hreset && (vcount == vcount_t'(`V_SYNC_ON - 1));
   assign vsync_off = hreset && (vcount == vcount_t'(`V_SYNC_OFF - 1));
   assign vreset    = hreset && (vcount == vcount_t'(`V_TOTAL - 1));

   // blank look-ahead for the next column
   assign next_hblank = hreset ? 1'b0 : (hblank_on ? 1'b1 : hblank);
   assign next_vblank = vreset ? 1'b0 : (vblank_on ? 1'b1 : vblank);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         hcount <= '0;
         vcount <= '0;
         hblank <= 1'b0;
         vblank <= 1'b0;
         hsync  <= 1'b1;
         vsync  <= 1'b1;
         blank  <= 1'b1;
      end else begin
         hcount <= hreset ? '0 : hcount + 1'b1;
         if (hreset) begin
            vcount <= vreset ? '0 : vcount + 1'b1;
         end
         hblank <= next_hblank;
         vblank <= next_vblank;
         // syncs are active low
         hsync  <= hsync_on ? 1'b0 : (hsync_off ? 1'b1 : hsync);
         vsync  <= vsync_on ? 1'b0 : (vsync_off ? 1'b1 : vsync);
         blank  <= next_vblank | next_hblank;
      end
   end

endmodule

/* verilog/frame_reader.sv */
// display reader with address forecast
`timescale 1ns/1ps
`include "video_cfg.svh"

module frame_reader
   import video_pkg::*;
(
   input  logic    clk,
   input  logic    arst_n,
   input  hcount_t hcount,
   input  vcount_t vcount,
   input  logic    hsync,
   input  logic    vsync,
   input  logic    blank,
   output vaddr_t  rd_addr,
   input  pixel_t  rd_data,
   output pixel_t  vid_pixel,
   output logic    vid_hsync,
   output logic    vid_vsync,
   output logic    vid_blank
);

   localparam int HW     = $bits(hcount_t) + 1;
   localparam int X_BITS = $clog2(`IMG_W);
   localparam int Y_BITS = $clog2(`IMG_H);

   logic [HW-1:0]      h_ahead;
   logic               line_wrap;
   hcount_t            h_fc;
   vcount_t            v_fc;
   hcount_t            x_img;
   vcount_t            y_img;
   logic               in_win;
   logic [`RD_LAT-1:0] in_win_q;

   //////////////////////////////////////////////////////////////////////
   // forecast RD_LAT columns ahead so data lands on time
   //////////////////////////////////////////////////////////////////////

   // extra bit so the sum cannot overflow before the wrap test
   assign h_ahead   = {1'b0, hcount} + HW'(`RD_LAT);
   assign line_wrap = (h_ahead >= HW'(`H_TOTAL));
   assign h_fc      = line_wrap ? hcount_t'(h_ahead - HW'(`H_TOTAL)) : hcount_t'(h_ahead);

   always_comb begin
      if (!line_wrap) begin
         v_fc = vcount;
      end else if (vcount == vcount_t'(`V_TOTAL - 1)) begin
         v_fc = '0;
      end else begin
         v_fc = vcount + 1'b1;
      end
   end

   // position inside the stored image
   assign x_img  = h_fc - hcount_t'(`X_OFF);
   assign y_img  = v_fc - vcount_t'(`Y_OFF);
   assign in_win = (h_fc >= hcount_t'(`X_OFF)) && (x_img < hcount_t'(`IMG_W)) &&
                   (v_fc >= vcount_t'(`Y_OFF)) && (y_img < vcount_t'(`IMG_H));

   assign rd_addr = {y_img[Y_BITS-1:0], x_img[X_BITS-1:0]};

   //////////////////////////////////////////////////////////////////////
   // output register, one cycle behind the counters
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         in_win_q  <= '0;
         vid_pixel <= '0;
         vid_hsync <= 1'b1;
         vid_vsync <= 1'b1;
         vid_blank <= 1'b1;
      end else begin
         // window flag travels with the read
         in_win_q[0] <= in_win;
         for (int i = 1; i < `RD_LAT; i++) begin
            in_win_q[i] <= in_win_q[i-1];
         end
         vid_hsync <= hsync;
         vid_vsync <= vsync;
         vid_blank <= blank;
         if (blank) begin
            vid_pixel <= '0;
         end else if (in_win_q[`RD_LAT-1]) begin
            vid_pixel <= rd_data;
         end else begin
            vid_pixel <= pixel_t'(`FILL_PIXEL);
         end
      end
   end

endmodule

/* verilog/camera_writer.sv */
// camera pixel writer for bank 0
`timescale 1ns/1ps
`include "video_cfg.svh"

module camera_writer
   import video_pkg::*;
(
   input  logic   clk,
   input  logic   arst_n,
   input  logic   cam_valid,
   input  logic   cam_frame_start,
   input  pixel_t cam_pixel,
   output vaddr_t cam_addr,
   output pixel_t cam_data,
   output logic   cam_we
);

   localparam int N_PIX = `IMG_W * `IMG_H;

   vaddr_t wr_ptr;
   vaddr_t this_addr;

   // frame start restarts at the top left pixel
   assign this_addr = cam_frame_start ? '0 : wr_ptr;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         cam_we <= 1'b0;
      end else begin
         cam_we <= cam_valid;
         if (cam_valid) begin
            // row-major, wrap after the last pixel
            wr_ptr <= (this_addr == vaddr_t'(N_PIX - 1)) ? '0 : this_addr + 1'b1;
         end else if (cam_frame_start) begin
            wr_ptr <= '0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (cam_valid) begin
         cam_addr <= this_addr;
         cam_data <= cam_pixel;
      end
   end

endmodule

/* verilog/frame_mirror.sv */
// bank copy engine with horizontal mirror
`timescale 1ns/1ps
`include "video_cfg.svh"

module frame_mirror
   import video_pkg::*;
(
   input  logic   clk,
   input  logic   arst_n,
   input  logic   copy_start,
   output vaddr_t src_addr,
   input  pixel_t src_data,
   output vaddr_t dst_addr,
   output pixel_t dst_data,
   output logic   dst_we,
   output logic   copy_done
);

   localparam int N_PIX  = `IMG_W * `IMG_H;
   localparam int X_BITS = $clog2(`IMG_W);

   typedef enum logic [1:0] {
      st_idle,
      st_run,
      st_drain
   } state_t;

   state_t             state;
   vaddr_t             src_cnt;
   logic               issue;
   logic               last_issue;
   vaddr_t             mirror_addr;
   logic [`RD_LAT-1:0] vld_q;
   logic [`RD_LAT-1:0] last_q;
   vaddr_t             dst_q [`RD_LAT];

   // one source read per cycle while running
   assign issue      = (state == st_run);
   assign last_issue = issue && (src_cnt == vaddr_t'(N_PIX - 1));
   assign src_addr   = src_cnt;

   // width is a power of two so inverting the column gives IMG_W-1-x
   assign mirror_addr = {src_cnt[$bits(vaddr_t)-1:X_BITS], ~src_cnt[X_BITS-1:0]};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= st_idle;
         src_cnt   <= '0;
         vld_q     <= '0;
         last_q    <= '0;
         copy_done <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (copy_start) begin
                  state   <= st_run;
                  src_cnt <= '0;
               end
            end
            st_run: begin
               src_cnt <= src_cnt + 1'b1;
               if (last_issue) begin
                  state <= st_drain;
               end
            end
            st_drain: begin
               // wait for the final write to leave the pipe
               if (last_q[`RD_LAT-1]) begin
                  state <= st_idle;
               end
            end
            default: state <= st_idle;
         endcase
         vld_q[0]  <= issue;
         last_q[0] <= last_issue;
         for (int i = 1; i < `RD_LAT; i++) begin
            vld_q[i]  <= vld_q[i-1];
            last_q[i] <= last_q[i-1];
         end
         copy_done <= last_q[`RD_LAT-1];
      end
   end

   // destination address follows its read through the bank latency
   always_ff @(posedge clk) begin
      dst_q[0] <= mirror_addr;
      for (int i = 1; i < `RD_LAT; i++) begin
         dst_q[i] <= dst_q[i-1];
      end
   end

   assign dst_addr = dst_q[`RD_LAT-1];
   assign dst_data = src_data;
   assign dst_we   = vld_q[`RD_LAT-1];

endmodule

/* verilog/bank_arbiter.sv */
// mode-driven bank routing
`timescale 1ns/1ps

module bank_arbiter
   import video_pkg::*;
(
   input  mode_t  mode,
   input  vaddr_t cam_addr,
   input  pixel_t cam_data,
   input  logic   cam_we,
   input  vaddr_t rd_addr,
   input  vaddr_t src_addr,
   input  vaddr_t dst_addr,
   input  pixel_t dst_data,
   input  logic   dst_we,
   output vaddr_t bank0_addr,
   output pixel_t bank0_wdata,
   output logic   bank0_we,
   output vaddr_t bank1_addr,
   output pixel_t bank1_wdata,
   output logic   bank1_we,
   input  pixel_t bank0_rdata,
   input  pixel_t bank1_rdata,
   output pixel_t rd_data,
   output pixel_t src_data
);

   always_comb begin
      // unowned banks idle at address 0, readers see 0
      bank0_addr  = '0;
      bank0_wdata = '0;
      bank0_we    = 1'b0;
      bank1_addr  = '0;
      bank1_wdata = '0;
      bank1_we    = 1'b0;
      rd_data     = '0;
      src_data    = '0;
      case (mode)
         // camera fills bank 0
         mode_view: begin
            bank0_addr  = cam_addr;
            bank0_wdata = cam_data;
            bank0_we    = cam_we;
         end
         mode_source: begin
            bank0_addr = rd_addr;
            rd_data    = bank0_rdata;
         end
         // mirror reads bank 0 and writes bank 1
         mode_copy: begin
            bank0_addr  = src_addr;
            src_data    = bank0_rdata;
            bank1_addr  = dst_addr;
            bank1_wdata = dst_data;
            bank1_we    = dst_we;
         end
         mode_result: begin
            bank1_addr = rd_addr;
            rd_data    = bank1_rdata;
         end
         default: ;
      endcase
   end

endmodule

/* verilog/zbt_bank.sv */
// pipelined pixel memory bank
`timescale 1ns/1ps
`include "video_cfg.svh"

module zbt_bank (
   input  logic                                clk,
   input  logic [$clog2(`IMG_W * `IMG_H)-1:0] addr,
   input  logic [7:0]                          wdata,
   input  logic                                we,
   output logic [7:0]                          rdata
);

   localparam int DEPTH = `IMG_W * `IMG_H;

   logic [7:0]               mem [DEPTH];
   logic [$clog2(DEPTH)-1:0] addr_q;

   always_ff @(posedge clk) begin
      // write lands at the edge that sees we
      if (we) begin
         mem[addr] <= wdata;
      end
      // address stage then data stage, two cycles to rdata
      addr_q <= addr;
      rdata  <= mem[addr_q];
   end

endmodule

/* verilog/video_frame_top.sv */
// video frame buffer top level
`timescale 1ns/1ps

module video_frame_top
   import video_pkg::*;
(
   input  logic   clk,
   input  logic   arst_n,
   input  mode_t  mode,
   input  logic   cam_valid,
   input  logic   cam_frame_start,
   input  pixel_t cam_pixel,
   input  logic   copy_start,
   output logic   copy_done,
   output pixel_t vid_pixel,
   output logic   vid_hsync,
   output logic   vid_vsync,
   output logic   vid_blank
);

   hcount_t hcount;
   vcount_t vcount;
   logic    hsync;
   logic    vsync;
   logic    blank;
   vaddr_t  rd_addr;
   pixel_t  rd_data;
   vaddr_t  cam_addr;
   pixel_t  cam_data;
   logic    cam_we;
   vaddr_t  src_addr;
   pixel_t  src_data;
   vaddr_t  dst_addr;
   pixel_t  dst_data;
   logic    dst_we;
   vaddr_t  bank0_addr;
   pixel_t  bank0_wdata;
   logic    bank0_we;
   pixel_t  bank0_rdata;
   vaddr_t  bank1_addr;
   pixel_t  bank1_wdata;
   logic    bank1_we;
   pixel_t  bank1_rdata;

   //////////////////////////////////////////////////////////////////////
   // raster and display path
   //////////////////////////////////////////////////////////////////////

   raster_timing timing (
      .clk    (clk),
      .arst_n (arst_n),
      .hcount (hcount),
      .vcount (vcount),
      .hsync  (hsync),
      .vsync  (vsync),
      .blank  (blank)
   );

   frame_reader reader (
      .clk       (clk),
      .arst_n    (arst_n),
      .hcount    (hcount),
      .vcount    (vcount),
      .hsync     (hsync),
      .vsync     (vsync),
      .blank     (blank),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .vid_pixel (vid_pixel),
      .vid_hsync (vid_hsync),
      .vid_vsync (vid_vsync),
      .vid_blank (vid_blank)
   );

   //////////////////////////////////////////////////////////////////////
   // memory writers
   //////////////////////////////////////////////////////////////////////

   camera_writer cam_wr (
      .clk             (clk),
      .arst_n          (arst_n),
      .cam_valid       (cam_valid),
      .cam_frame_start (cam_frame_start),
      .cam_pixel       (cam_pixel),
      .cam_addr        (cam_addr),
      .cam_data        (cam_data),
      .cam_we          (cam_we)
   );

   frame_mirror mirror (
      .clk        (clk),
      .arst_n     (arst_n),
      .copy_start (copy_start),
      .src_addr   (src_addr),
      .src_data   (src_data),
      .dst_addr   (dst_addr),
      .dst_data   (dst_data),
      .dst_we     (dst_we),
      .copy_done  (copy_done)
   );

   //////////////////////////////////////////////////////////////////////
   // bank ownership and the two banks
   //////////////////////////////////////////////////////////////////////

   bank_arbiter arbiter (
      .mode        (mode),
      .cam_addr    (cam_addr),
      .cam_data    (cam_data),
      .cam_we      (cam_we),
      .rd_addr     (rd_addr),
      .src_addr    (src_addr),
      .dst_addr    (dst_addr),
      .dst_data    (dst_data),
      .dst_we      (dst_we),
      .bank0_addr  (bank0_addr),
      .bank0_wdata (bank0_wdata),
      .bank0_we    (bank0_we),
      .bank1_addr  (bank1_addr),
      .bank1_wdata (bank1_wdata),
      .bank1_we    (bank1_we),
      .bank0_rdata (bank0_rdata),
      .bank1_rdata (bank1_rdata),
      .rd_data     (rd_data),
      .src_data    (src_data)
   );

   zbt_bank bank0 (
      .clk   (clk),
      .addr  (bank0_addr),
      .wdata (bank0_wdata),
      .we    (bank0_we),
      .rdata (bank0_rdata)
   );

   zbt_bank bank1 (
      .clk   (clk),
      .addr  (bank1_addr),
      .wdata (bank1_wdata),
      .we    (bank1_we),
      .rdata (bank1_rdata)
   );

endmodule

/* tb/tb_video_frame.sv */
// video frame buffer testbench
`timescale 1ns/1ps
`include "video_cfg.svh"

module tb_video_frame
   import video_pkg::*;
();

   localparam int N_PIX      = `IMG_W * `IMG_H;
   localparam int FRAME      = `H_TOTAL * `V_TOTAL;
   localparam int VIS_PIX    = `H_ACTIVE * `V_ACTIVE;
   localparam int COPY_LAT   = N_PIX + `RD_LAT + 1;
   localparam int MAX_CYCLES = 12 * FRAME + COPY_LAT;

   logic   clk;
   logic   arst_n;
   mode_t  mode;
   logic   cam_valid;
   logic   cam_frame_start;
   pixel_t cam_pixel;
   logic   copy_start;
   logic   copy_done;
   pixel_t vid_pixel;
   logic   vid_hsync;
   logic   vid_vsync;
   logic   vid_blank;

   // reference images of bank 0 and bank 1
   pixel_t img0 [N_PIX];
   pixel_t img1 [N_PIX];
   int     cam_ptr;

   int     err_cnt;
   int     chk_cnt;
   int     pix_cnt;
   int     cycle_cnt;
   logic   check_en;
   int     row;
   int     col;
   logic   prev_blank;
   logic   prev_vsync;

   video_frame_top UUT (
      .clk             (clk),
      .arst_n          (arst_n),
      .mode            (mode),
      .cam_valid       (cam_valid),
      .cam_frame_start (cam_frame_start),
      .cam_pixel       (cam_pixel),
      .copy_start      (copy_start),
      .copy_done       (copy_done),
      .vid_pixel       (vid_pixel),
      .vid_hsync       (vid_hsync),
      .vid_vsync       (vid_vsync),
      .vid_blank       (vid_blank)
   );

   // 40 ns period
   always #20 clk = ~clk;

   // run limit
   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("sim failed");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////

   // black in blank is never asked for, only visible positions
   function automatic pixel_t expected_pixel(mode_t m, int x, int y);
      int ix;
      int iy;
      ix = x - `X_OFF;
      iy = y - `Y_OFF;
      if (ix < 0 || ix >= `IMG_W || iy < 0 || iy >= `IMG_H) begin
         return `FILL_PIXEL;
      end
      case (m)
         mode_source: return img0[iy * `IMG_W + ix];
         mode_result: return img1[iy * `IMG_W + ix];
         // view and copy modes hand the display zeros
         default:     return 8'h00;
      endcase
   endfunction

   // screen position from the output syncs, compare on the falling edge
   always @(negedge clk) begin
      pixel_t exp_px;
      if (prev_vsync && !vid_vsync) begin
         row = -1;
      end
      if (!vid_blank) begin
         if (prev_blank) begin
            row++;
            col = 0;
         end else begin
            col++;
         end
         if (check_en) begin
            exp_px = expected_pixel(mode, col, row);
            chk_cnt++;
            pix_cnt++;
            if (vid_pixel !== exp_px) begin
               err_cnt++;
               $display("ERR %0t: pixel (%0d,%0d) is %h, expected %h",
                        $time, col, row, vid_pixel, exp_px);
            end
         end
      end
      prev_blank = vid_blank;
      prev_vsync = vid_vsync;
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus tasks
   //////////////////////////////////////////////////////////////////////

   // returns on the rising edge that first sees vid_vsync low
   task automatic wait_vsync();
      logic prev_v;
      prev_v = vid_vsync;
      @(posedge clk);
      while (!(prev_v && !vid_vsync)) begin
         prev_v = vid_vsync;
         @(posedge clk);
      end
   endtask

   // one frame from vsync fall to vsync fall
   task automatic measure_frame();
      int   cycles;
      int   lines;
      int   low_run;
      logic prev_v;
      lines   = 0;
      low_run = 0;
      prev_v  = vid_vsync;
      @(posedge clk);
      cycles = 1;
      while (!(prev_v && !vid_vsync)) begin
         if (!vid_hsync) begin
            low_run++;
         end else if (low_run != 0) begin
            chk_cnt++;
            if (low_run != `H_SYNC_OFF - `H_SYNC_ON) begin
               err_cnt++;
               $display("ERR %0t: hsync low for %0d cycles", $time, low_run);
            end
            lines++;
            low_run = 0;
         end
         prev_v = vid_vsync;
         @(posedge clk);
         cycles++;
      end
      chk_cnt += 2;
      if (lines != `V_TOTAL) begin
         err_cnt++;
         $display("ERR %0t: %0d lines per frame, expected %0d", $time, lines, `V_TOTAL);
      end
      if (cycles != FRAME) begin
         err_cnt++;
         $display("ERR %0t: frame of %0d cycles, expected %0d", $time, cycles, FRAME);
      end
   endtask

   // camera stream with random gaps, frame start on the first pixel
   task automatic send_frame(int n);
      int     gap;
      pixel_t px;
      for (int i = 0; i < n; i++) begin
         gap = int'($urandom % 3);
         repeat (gap) begin
            @(posedge clk);
            cam_valid       <= 1'b0;
            cam_frame_start <= 1'b0;
         end
         px = pixel_t'($urandom);
         @(posedge clk);
         cam_valid       <= 1'b1;
         cam_frame_start <= (i == 0);
         cam_pixel       <= px;
         // row-major fill that restarts on frame start
         if (i == 0) begin
            cam_ptr = 0;
         end
         if (mode == mode_view) begin
            img0[cam_ptr] = px;
         end
         cam_ptr = (cam_ptr + 1) % N_PIX;
      end
      @(posedge clk);
      cam_valid       <= 1'b0;
      cam_frame_start <= 1'b0;
   endtask

   // check every visible pixel up to the next vsync fall
   task automatic check_frame();
      int pix0;
      pix0     = pix_cnt;
      check_en = 1'b1;
      wait_vsync();
      check_en = 1'b0;
      chk_cnt++;
      if (pix_cnt - pix0 != VIS_PIX) begin
         err_cnt++;
         $display("ERR %0t: %0d visible pixels, expected %0d", $time, pix_cnt - pix0, VIS_PIX);
      end
   endtask

   // pulse copy_start and time copy_done in rising edges
   task automatic run_copy();
      int lat;
      copy_start <= 1'b1;
      lat = 0;
      @(negedge clk);
      while (!copy_done && lat < 2 * COPY_LAT) begin
         @(posedge clk);
         copy_start <= 1'b0;
         lat++;
         @(negedge clk);
      end
      chk_cnt++;
      if (lat != COPY_LAT) begin
         err_cnt++;
         $display("ERR %0t: copy_done after %0d cycles, expected %0d", $time, lat, COPY_LAT);
      end
      @(negedge clk);
      chk_cnt++;
      if (copy_done !== 1'b0) begin
         err_cnt++;
         $display("ERR %0t: copy_done high for more than one cycle", $time);
      end
      // bank 1 gets bank 0 with columns reversed
      for (int r = 0; r < `IMG_H; r++) begin
         for (int c = 0; c < `IMG_W; c++) begin
            img1[r * `IMG_W + (`IMG_W - 1 - c)] = img0[r * `IMG_W + c];
         end
      end
   endtask

   task automatic end_test(int num, string name, int err0);
      if (err_cnt == err0) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: %0d errors", num, name, err_cnt - err0);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      int err0;
      void'($urandom(32'h89ae8236));
      clk             = 1'b0;
      arst_n          <= 1'b0;
      mode            <= mode_view;
      cam_valid       <= 1'b0;
      cam_frame_start <= 1'b0;
      cam_pixel       <= '0;
      copy_start      <= 1'b0;
      err_cnt    = 0;
      chk_cnt    = 0;
      pix_cnt    = 0;
      cycle_cnt  = 0;
      check_en   = 1'b0;
      cam_ptr    = 0;
      row        = -1;
      col        = 0;
      prev_blank = 1'b1;
      prev_vsync = 1'b1;
      repeat (3) @(posedge clk);

      // reset levels, then sync widths and frame length
      err0 = err_cnt;
      chk_cnt++;
      if (vid_hsync !== 1'b1 || vid_vsync !== 1'b1 || vid_blank !== 1'b1 ||
          vid_pixel !== 8'h00 || copy_done !== 1'b0) begin
         err_cnt++;
         $display("ERR %0t: outputs not at reset levels", $time);
      end
      arst_n <= 1'b1;
      wait_vsync();
      measure_frame();
      end_test(1, "raster", err0);

      // camera owns bank 0, display window is black
      err0 = err_cnt;
      mode <= mode_view;
      send_frame(N_PIX);
      wait_vsync();
      check_frame();
      end_test(2, "view", err0);

      err0 = err_cnt;
      mode <= mode_source;
      check_frame();
      end_test(3, "source", err0);

      // partial frame overwritten after a new frame start
      err0 = err_cnt;
      mode <= mode_view;
      send_frame(N_PIX / 3);
      send_frame(N_PIX);
      wait_vsync();
      mode <= mode_source;
      check_frame();
      end_test(4, "restart", err0);

      err0 = err_cnt;
      mode <= mode_copy;
      run_copy();
      wait_vsync();
      mode <= mode_result;
      check_frame();
      end_test(5, "mirror", err0);

      $display("%0d checks, %0d errors", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

/* vlog.f */
+incdir+verilog
verilog/video_pkg.sv
verilog/raster_timing.sv
verilog/frame_reader.sv
verilog/camera_writer.sv
verilog/frame_mirror.sv
verilog/bank_arbiter.sv
verilog/zbt_bank.sv
verilog/video_frame_top.sv
tb/tb_video_frame.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and search the log for failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_video_frame \
   -f vlog.f -o tb_video_frame > build.log 2>&1 \
   || { cat build.log; echo "build error"; exit 1; }

./obj_dir/tb_video_frame > sim.log 2>&1 \
   || { cat sim.log; echo "simulation exited with an error"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
